// ==== common/rv_pkg.sv ====
// rv_pkg: shared widths, types, encodings and reset values for the RV32I pipeline
package rv_pkg;

  localparam int XLEN      = 32;  // Data and address width
  localparam int REG_COUNT = 32;  // Architectural registers x0..x31

  typedef logic [4:0]      reg_idx_t;  // Register index
  typedef logic [XLEN-1:0] word_t;     // Data / address word

  // Reset and fetch constants
  localparam word_t RESET_PC = 32'h0000_0000;
  localparam word_t PC_STEP  = 32'h0000_0004;
  localparam word_t NOP_INST = 32'h0000_0013;  // addi x0,x0,0

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_R     = 7'b0110011,  // Register-register ALU
    OP_IMM   = 7'b0010011,  // Register-immediate ALU
    OP_LOAD  = 7'b0000011,  // lw
    OP_STORE = 7'b0100011,  // sw
    OP_LUI   = 7'b0110111,
    OP_AUIPC = 7'b0010111
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SRA = 4'd7   // Arithmetic right shift
  } alu_op_e;

  // First ALU operand source
  typedef enum logic [1:0] {
    OPA_RS1  = 2'd0,  // Forwarded rs1
    OPA_PC   = 2'd1,  // For auipc
    OPA_ZERO = 2'd2   // For lui
  } opa_sel_e;

endpackage

// ==== decode/decode_stage.sv ====
// decode_stage: register read, load-use hazard detection and the ID/EX pipeline register
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    id_pc,
  input  word_t    id_inst,
  input  logic     wb_we,         // Writeback port
  input  reg_idx_t wb_rd,
  input  word_t    wb_data,
  output logic     stall,         // To fetch
  output word_t    ex_pc,
  output reg_idx_t ex_rs1,
  output reg_idx_t ex_rs2,
  output word_t    ex_rs1_data,
  output word_t    ex_rs2_data,
  output word_t    ex_imm,
  output reg_idx_t ex_rd,
  output alu_op_e  ex_alu_op,
  output opa_sel_e ex_opa_sel,
  output logic     ex_use_imm,
  output logic     ex_reg_write,
  output logic     ex_mem_load,
  output logic     ex_mem_write
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_e  alu_op;
  opa_sel_e opa_sel;
  logic     use_imm;
  logic     reg_write;
  logic     mem_load;
  logic     mem_write;
  word_t    rs1_data;
  word_t    rs2_data;

  inst_decoder i_dec (
    .inst      (id_inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .opa_sel   (opa_sel),
    .use_imm   (use_imm),
    .reg_write (reg_write),
    .mem_load  (mem_load),
    .mem_write (mem_write)
  );

  reg_file i_rf (
    .clk      (clk),
    .we       (wb_we),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // Load in execute feeding either source field here.
  // Raw fields are compared, so an unused field may cause a spare stall
  assign stall = ex_mem_load && ex_reg_write && (ex_rd == rs1 || ex_rd == rs2);

  // Control half of ID/EX, cleared on reset and on a bubble
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex_reg_write <= 1'b0;
      ex_mem_load  <= 1'b0;
      ex_mem_write <= 1'b0;
    end
    else if (stall)
    begin
      ex_reg_write <= 1'b0;  // Bubble
      ex_mem_load  <= 1'b0;
      ex_mem_write <= 1'b0;
    end
    else
    begin
      ex_reg_write <= reg_write;
      ex_mem_load  <= mem_load;
      ex_mem_write <= mem_write;
    end
  end

  // Payload half; content of a bubble is don't-care
  always_ff @(posedge clk)
  begin
    ex_pc       <= id_pc;
    ex_rs1      <= rs1;
    ex_rs2      <= rs2;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
    ex_rd       <= rd;
    ex_alu_op   <= alu_op;
    ex_opa_sel  <= opa_sel;
    ex_use_imm  <= use_imm;
  end

endmodule

// ==== decode/inst_decoder.sv ====
// inst_decoder: maps an RV32I instruction to its control set and sign-extended immediate
`timescale 1ns/1ps

module inst_decoder import rv_pkg::*; (
  input  word_t    inst,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output alu_op_e  alu_op,
  output opa_sel_e opa_sel,
  output logic     use_imm,    // Operand b from imm
  output logic     reg_write,
  output logic     mem_load,
  output logic     mem_write
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       alt;       // funct7[5], sub / sra select
  logic       writes_rd; // Opcode writes a register
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign alt    = inst[30];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};

  // Register-register and register-immediate ALU ops share funct3 decoding
  always_comb
  begin
    unique case (funct3)
      3'b000:  alu_op = (opcode == OP_R && alt) ? ALU_SUB : ALU_ADD; // No subi
      3'b001:  alu_op = ALU_SLL;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      3'b111:  alu_op = ALU_AND;
      default: alu_op = ALU_ADD;  // slt/sltu not supported
    endcase
    // Address and upper-immediate forms all add
    if (opcode != OP_R && opcode != OP_IMM)
      alu_op = ALU_ADD;
  end

  always_comb
  begin
    imm       = imm_i;
    opa_sel   = OPA_RS1;
    use_imm   = 1'b1;
    writes_rd = 1'b0;
    mem_load  = 1'b0;
    mem_write = 1'b0;
    case (opcode)
      OP_R:
      begin
        use_imm   = 1'b0;
        writes_rd = 1'b1;
      end
      OP_IMM:   writes_rd = 1'b1;  // Shift amount sits in imm[4:0]
      OP_LOAD:
      begin
        writes_rd = 1'b1;
        mem_load  = 1'b1;
      end
      OP_STORE:
      begin
        imm       = imm_s;
        mem_write = 1'b1;
      end
      OP_LUI:
      begin
        imm       = imm_u;
        opa_sel   = OPA_ZERO;  // 0 + imm
        writes_rd = 1'b1;
      end
      OP_AUIPC:
      begin
        imm       = imm_u;
        opa_sel   = OPA_PC;    // pc + imm
        writes_rd = 1'b1;
      end
      default:  use_imm = 1'b0;  // Unknown opcode acts as nop
    endcase
  end

  // x0 is never written
  assign reg_write = writes_rd && (rd != '0);

endmodule

// ==== decode/reg_file.sv ====
// reg_file: 32 x 32 integer register file, two reads and one write with write-through
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     we,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [REG_COUNT];  // regs[0] never read

  always_ff @(posedge clk)
  begin
    if (we)
      regs[rd] <= rd_data;  // Written at end of writeback cycle
  end

  // Same-cycle write returns the new value
  always_comb
  begin
    if (rs1 == '0)                rs1_data = '0;
    else if (we && rd == rs1)     rs1_data = rd_data;
    else                          rs1_data = regs[rs1];

    if (rs2 == '0)                rs2_data = '0;
    else if (we && rd == rs2)     rs2_data = rd_data;
    else                          rs2_data = regs[rs2];
  end

endmodule

// ==== execute/execute_stage.sv ====
// execute_stage: operand forwarding, integer ALU and the EX/MEM pipeline register
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    ex_pc,
  input  reg_idx_t ex_rs1,
  input  reg_idx_t ex_rs2,
  input  word_t    ex_rs1_data,
  input  word_t    ex_rs2_data,
  input  word_t    ex_imm,
  input  reg_idx_t ex_rd,
  input  alu_op_e  ex_alu_op,
  input  opa_sel_e ex_opa_sel,
  input  logic     ex_use_imm,
  input  logic     ex_reg_write,
  input  logic     ex_mem_load,
  input  logic     ex_mem_write,
  input  logic     wb_we,           // Writeback forwarding source
  input  reg_idx_t wb_rd,
  input  word_t    wb_data,
  output word_t    mem_alu_result,  // Also the data memory address
  output word_t    mem_store_data,
  output logic     mem_write,
  output logic     mem_load,
  output logic     mem_reg_write,
  output reg_idx_t mem_rd
);

  word_t      rs1_fwd;
  word_t      rs2_fwd;  // Feeds operand b and store data
  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_result;

  // Youngest producer wins. A load never sits in memory with a
  // consumer here because decode stalls that pair
  function automatic word_t forward_operand(input reg_idx_t src, input word_t rf_value);
    word_t value;
    if (mem_reg_write && mem_rd == src)
      value = mem_alu_result;
    else if (wb_we && wb_rd == src)
      value = wb_data;
    else
      value = rf_value;
    return value;
  endfunction

  assign rs1_fwd = forward_operand(ex_rs1, ex_rs1_data);
  assign rs2_fwd = forward_operand(ex_rs2, ex_rs2_data);

  always_comb
  begin
    unique case (ex_opa_sel)
      OPA_PC:   op_a = ex_pc;
      OPA_ZERO: op_a = '0;
      default:  op_a = rs1_fwd;
    endcase
  end

  assign op_b  = ex_use_imm ? ex_imm : rs2_fwd;
  assign shamt = op_b[4:0];  // Upper bits ignored for shifts

  always_comb
  begin
    unique case (ex_alu_op)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      ALU_SLL: alu_result = op_a << shamt;
      ALU_SRL: alu_result = op_a >> shamt;
      ALU_SRA: alu_result = word_t'($signed(op_a) >>> shamt);  // Sign fill
      default: alu_result = op_a + op_b;  // ALU_ADD
    endcase
  end

  // EX/MEM controls
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mem_write     <= 1'b0;
      mem_load      <= 1'b0;
      mem_reg_write <= 1'b0;
    end
    else
    begin
      mem_write     <= ex_mem_write;
      mem_load      <= ex_mem_load;
      mem_reg_write <= ex_reg_write;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk)
  begin
    mem_alu_result <= alu_result;
    mem_store_data <= rs2_fwd;
    mem_rd         <= ex_rd;
  end

endmodule

// ==== hdl/fetch_stage.sv ====
// fetch_stage: program counter and IF/ID register, both frozen during a load-use stall
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,    // Hold pc and IF/ID
  input  word_t inst,     // Instruction at pc
  output word_t pc,
  output word_t id_pc,
  output word_t id_inst
);

  // Sequential fetch only, no redirect
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc <= RESET_PC;
    end
    else if (!stall)
    begin
      pc <= pc + PC_STEP;
    end
  end

  // IF/ID starts as a nop so decode sees nothing after reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      id_pc   <= RESET_PC;
      id_inst <= NOP_INST;
    end
    else if (!stall)
    begin
      id_pc   <= pc;
      id_inst <= inst;  // Word at pc this cycle
    end
  end

endmodule

// ==== hdl/mem_wb_stage.sv ====
// mem_wb_stage: MEM/WB pipeline register and selection of the write-back value
`timescale 1ns/1ps

module mem_wb_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    mem_alu_result,
  input  word_t    mem_rdata,      // Load data, same cycle as address
  input  logic     mem_load,
  input  logic     mem_reg_write,
  input  reg_idx_t mem_rd,
  output logic     wb_we,
  output reg_idx_t wb_rd,
  output word_t    wb_data         // To register file and forwarding
);

  logic  wb_load;
  word_t wb_alu_result;
  word_t wb_rdata;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wb_we   <= 1'b0;
      wb_load <= 1'b0;
    end
    else
    begin
      wb_we   <= mem_reg_write;
      wb_load <= mem_load;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_rd         <= mem_rd;
    wb_alu_result <= mem_alu_result;
    wb_rdata      <= mem_rdata;  // Captured at end of memory cycle
  end

  assign wb_data = wb_load ? wb_rdata : wb_alu_result;

endmodule

// ==== hdl/rv_pipe_top.sv ====
// rv_pipe_top: five-stage RV32I integer pipeline with instruction and data memory ports
`timescale 1ns/1ps

module rv_pipe_top import rv_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  output word_t pc,         // Instruction fetch address
  input  word_t inst,       // Instruction at pc, same cycle
  output word_t mem_addr,   // Data memory address
  output word_t mem_wdata,  // Store data
  output logic  mem_write,  // Store strobe
  input  word_t mem_rdata   // Load data for mem_addr, same cycle
);

  // IF/ID
  word_t    id_pc;
  word_t    id_inst;
  logic     stall;  // Load-use hold

  // ID/EX
  word_t    ex_pc;
  reg_idx_t ex_rs1;
  reg_idx_t ex_rs2;
  word_t    ex_rs1_data;
  word_t    ex_rs2_data;
  word_t    ex_imm;
  reg_idx_t ex_rd;
  alu_op_e  ex_alu_op;
  opa_sel_e ex_opa_sel;
  logic     ex_use_imm;
  logic     ex_reg_write;
  logic     ex_mem_load;
  logic     ex_mem_write;

  // EX/MEM controls not leaving the core
  logic     mem_load;
  logic     mem_reg_write;
  reg_idx_t mem_rd;

  // MEM/WB
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;

  fetch_stage i_fetch (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .inst    (inst),
    .pc      (pc),
    .id_pc   (id_pc),
    .id_inst (id_inst)
  );

  decode_stage i_decode (
    .clk          (clk),
    .reset        (reset),
    .id_pc        (id_pc),
    .id_inst      (id_inst),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .stall        (stall),
    .ex_pc        (ex_pc),
    .ex_rs1       (ex_rs1),
    .ex_rs2       (ex_rs2),
    .ex_rs1_data  (ex_rs1_data),
    .ex_rs2_data  (ex_rs2_data),
    .ex_imm       (ex_imm),
    .ex_rd        (ex_rd),
    .ex_alu_op    (ex_alu_op),
    .ex_opa_sel   (ex_opa_sel),
    .ex_use_imm   (ex_use_imm),
    .ex_reg_write (ex_reg_write),
    .ex_mem_load  (ex_mem_load),
    .ex_mem_write (ex_mem_write)
  );

  // EX/MEM outputs go straight to the data memory
  execute_stage i_execute (
    .clk            (clk),
    .reset          (reset),
    .ex_pc          (ex_pc),
    .ex_rs1         (ex_rs1),
    .ex_rs2         (ex_rs2),
    .ex_rs1_data    (ex_rs1_data),
    .ex_rs2_data    (ex_rs2_data),
    .ex_imm         (ex_imm),
    .ex_rd          (ex_rd),
    .ex_alu_op      (ex_alu_op),
    .ex_opa_sel     (ex_opa_sel),
    .ex_use_imm     (ex_use_imm),
    .ex_reg_write   (ex_reg_write),
    .ex_mem_load    (ex_mem_load),
    .ex_mem_write   (ex_mem_write),
    .wb_we          (wb_we),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .mem_alu_result (mem_addr),
    .mem_store_data (mem_wdata),
    .mem_write      (mem_write),
    .mem_load       (mem_load),
    .mem_reg_write  (mem_reg_write),
    .mem_rd         (mem_rd)
  );

  mem_wb_stage i_mem_wb (
    .clk            (clk),
    .reset          (reset),
    .mem_alu_result (mem_addr),
    .mem_rdata      (mem_rdata),
    .mem_load       (mem_load),
    .mem_reg_write  (mem_reg_write),
    .mem_rd         (mem_rd),
    .wb_we          (wb_we),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data)
  );

endmodule

// ==== list.f ====
+incdir+verif
common/rv_pkg.sv
decode/inst_decoder.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/fetch_stage.sv
hdl/mem_wb_stage.sv
hdl/rv_pipe_top.sv
verif/tb_rv_pipe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RV32I pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_rv_pipe -Mdir obj_dir -o tb_rv_pipe -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_pipe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
exit 1

// ==== verif/tb_tests.svh ====
// tb_tests: instruction encoders and the directed tests of the RV32I pipeline
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                 input int f3, input int rd);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R};
endfunction

function automatic word_t i_type(input opcode_e op, input int imm, input int rs1,
                                 input int f3, input int rd);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic word_t s_type(input int imm, input int rs2, input int rs1);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};  // sw only
endfunction

function automatic word_t u_type(input opcode_e op, input int imm20, input int rd);
  return {imm20[19:0], rd[4:0], op};
endfunction

task automatic emit(input word_t w);
  prog.push_back(w);
endtask

// lui + addi, upper part rounded for the signed low half
task automatic load_const(input int rd, input word_t value);
  word_t upper;
  upper = value + 32'h800;
  emit(u_type(OP_LUI, int'(upper >> 12), rd));
  emit(i_type(OP_IMM, int'(value), rd, 0, rd));
endtask

// Result in x5, stored at off(x10)
task automatic alu_then_store(input int f7, input int f3, input int rs1, input int rs2,
                              input int off);
  emit(r_type(f7, rs2, rs1, f3, 5));
  emit(s_type(off, 5, 10));
endtask

task automatic imm_then_store(input int f3, input int imm, input int off);
  emit(i_type(OP_IMM, imm, 1, f3, 5));  // Source always x1
  emit(s_type(off, 5, 10));
endtask

task automatic reset_and_fetch();
  begin_test("reset and fetch");
  run_program(0);  // Nops only, pc must step every edge
  end_test();
endtask

task automatic register_alu_ops();
  begin_test("register ALU ops");
  load_const(1, 32'h8765_4321);  // Negative
  load_const(2, 32'h0000_0013);
  load_const(3, 32'h0000_0025);  // 37, low five bits give 5
  load_const(4, 32'h1234_5678);
  load_const(10, 32'h0000_0100);
  alu_then_store(0, 0, 1, 4, 0);   // add
  alu_then_store(32, 0, 1, 4, 4);  // sub
  alu_then_store(0, 7, 1, 4, 8);
  alu_then_store(0, 6, 1, 4, 12);
  alu_then_store(0, 4, 1, 4, 16);
  alu_then_store(0, 1, 4, 3, 20);  // sll by 37
  alu_then_store(0, 5, 1, 3, 24);
  alu_then_store(32, 5, 1, 3, 28); // sra of negative
  alu_then_store(32, 5, 1, 2, 32);
  run_program(0);
  end_test();
endtask

task automatic immediate_ops();
  begin_test("immediates");
  load_const(1, 32'h89AB_CDEF);
  load_const(10, 32'h0000_0200);
  imm_then_store(0, -1234, 0);
  imm_then_store(7, -256, 4);
  imm_then_store(6, -2048, 8);
  imm_then_store(4, -1, 12);
  imm_then_store(1, 7, 16);
  imm_then_store(5, 13, 20);
  imm_then_store(5, 1024 + 13, 24);  // srai
  emit(u_type(OP_LUI, 20'hFEDCB, 5));
  emit(s_type(28, 5, 10));
  emit(u_type(OP_AUIPC, 20'h12345, 6));  // Sits at 0x50
  emit(s_type(32, 6, 10));
  run_program(0);
  end_test();
endtask

task automatic forwarding_paths();
  begin_test("forwarding");
  load_const(10, 32'h0000_0300);
  emit(i_type(OP_IMM, 100, 0, 0, 1));
  emit(i_type(OP_IMM, 23, 1, 0, 2));   // From memory stage
  emit(r_type(0, 2, 1, 0, 3));         // x1 from writeback, x2 from memory
  emit(s_type(0, 3, 10));              // Store data just produced
  emit(i_type(OP_IMM, 8, 10, 0, 11));
  emit(s_type(0, 2, 11));              // Base just produced
  emit(r_type(32, 1, 3, 0, 4));
  emit(r_type(0, 3, 2, 4, 5));
  emit(r_type(0, 5, 4, 0, 6));         // Distance two and one
  emit(s_type(4, 6, 11));
  emit(i_type(OP_IMM, 1, 0, 0, 8));
  emit(i_type(OP_IMM, 2, 0, 0, 8));
  emit(r_type(0, 8, 8, 0, 9));         // Youngest x8 wins
  emit(s_type(12, 9, 11));
  emit(s_type(16, 4, 11));
  run_program(0);
  end_test();
endtask

task automatic load_use_stall();
  begin_test("load-use");
  load_const(10, 32'h0000_0040);
  emit(i_type(OP_LOAD, 0, 10, 2, 5));
  emit(r_type(0, 10, 5, 0, 6));        // Uses x5 as rs1
  emit(s_type(256, 6, 10));
  emit(i_type(OP_LOAD, 4, 10, 2, 7));
  emit(r_type(0, 7, 7, 0, 8));         // Both sources
  emit(s_type(260, 8, 10));
  emit(i_type(OP_LOAD, 8, 10, 2, 9));
  emit(r_type(32, 9, 10, 0, 12));      // Uses x9 as rs2
  emit(s_type(264, 12, 10));
  run_program(3);  // One hold per pair
  end_test();
endtask

task automatic zero_reg_and_unknown();
  begin_test("x0 and unknown opcodes");
  load_const(1, 32'h1111_2222);
  load_const(10, 32'h0000_0380);
  emit(i_type(OP_IMM, 55, 0, 0, 0));   // Dropped write
  emit(r_type(0, 1, 1, 0, 0));
  emit(r_type(0, 1, 0, 0, 6));         // x0 must not forward
  emit(s_type(0, 0, 10));
  emit(s_type(4, 6, 10));
  emit(i_type(OP_IMM, 7, 0, 0, 5));
  emit({7'h00, 5'd1, 5'd1, 3'b000, 5'd5, 7'b1111111});  // Undefined, rd x5
  emit({12'h008, 5'd10, 3'b010, 5'd5, 7'b0100111});     // Store-like, undefined
  emit(s_type(8, 5, 10));              // x5 still 7
  run_program(0);
  end_test();
endtask

`endif

// ==== verif/tb_rv_pipe.sv ====
// tb_rv_pipe: testbench for the RV32I pipeline with memory models and an ISA reference model
`timescale 1ns/1ps

module tb_rv_pipe import rv_pkg::*; ();

  localparam int IMEM_WORDS    = 128;  // Indexed by pc[8:2]
  localparam int DMEM_WORDS    = 256;  // Indexed by addr[9:2]
  localparam int DRAIN         = 10;   // Nops run after the last instruction
  localparam int STORE_TIMEOUT = 40;   // Cycles allowed between stores
  localparam int RUN_LIMIT     = 400;  // Cycles allowed per program

  logic  clk   = 1'b0;
  logic  reset = 1'b1;
  word_t pc;
  word_t inst;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_write;
  word_t mem_rdata;

  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t model_mem [DMEM_WORDS];  // ISA model's view of dmem
  word_t model_regs [REG_COUNT];  // Kept across tests like the DUT's
  word_t prog [$];                // Program under construction
  word_t exp_addr [$];            // Predicted stores, in order
  word_t exp_data [$];

  int    seed;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    total_errors = 0;
  int    test_errors  = 0;
  string test_name;

  rv_pipe_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_write (mem_write),
    .mem_rdata (mem_rdata)
  );

  always #10 clk = ~clk;  // 20 ns period

  assign inst      = imem[pc[8:2]];        // Combinational fetch
  assign mem_rdata = dmem[mem_addr[9:2]];  // Same-cycle read data

  always @(posedge clk)
  begin
    if (mem_write)
      dmem[mem_addr[9:2]] <= mem_wdata;
  end

  task automatic report_mismatch(input string sig, input word_t got, input word_t exp);
    $display("FAILED %s got %h expected %h", sig, got, exp);
    test_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR: %s", what);
    test_errors++;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    prog.delete();
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors == 0)
      $display("test %s: ok", test_name);
    else
    begin
      $display("test %s: %0d errors", test_name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
  endtask

  // Program words first, nops behind
  task automatic load_program();
    int n;
    for (n = 0; n < IMEM_WORDS; n++)
      imem[n] = (n < prog.size()) ? prog[n] : NOP_INST;
  endtask

  // RV32I semantics of the supported ALU ops
  function automatic word_t compute_alu(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
    word_t r;
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b100:  r = a ^ b;
      3'b101:  r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  r = a | b;
      3'b111:  r = a & b;
      default: r = '0;  // Not used by the tests
    endcase
    return r;
  endfunction

  // ISA model, one instruction at a time in program order
  task automatic predict_stores();
    int    n;
    word_t ins;
    word_t a;
    word_t b;
    word_t res;
    word_t ea;
    word_t imm_i;
    word_t imm_s;
    logic  wr;
    exp_addr.delete();
    exp_data.delete();
    model_mem = dmem;  // Snapshot before the run
    for (n = 0; n < prog.size(); n++)
    begin
      ins   = prog[n];
      a     = model_regs[ins[19:15]];
      b     = model_regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      res   = '0;
      wr    = 1'b1;
      case (ins[6:0])
        OP_R:     res = compute_alu(ins[14:12], ins[30], a, b);
        OP_IMM:   res = compute_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
        OP_LOAD:
        begin
          ea  = a + imm_i;
          res = model_mem[ea[9:2]];
        end
        OP_STORE:
        begin
          ea = a + imm_s;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
          model_mem[ea[9:2]] = b;
          wr = 1'b0;
        end
        OP_LUI:   res = {ins[31:12], 12'b0};
        OP_AUIPC: res = word_t'(n * 4) + {ins[31:12], 12'b0};
        default:  wr = 1'b0;  // Undefined opcode does nothing
      endcase
      if (wr && ins[11:7] != 5'd0)
        model_regs[ins[11:7]] = res;
    end
  endtask

  task automatic reset_dut();
    int n;
    reset = 1'b1;
    for (n = 0; n < 5; n++)
    begin
      @(negedge clk);
      if (pc !== RESET_PC)
        report_mismatch("pc", pc, RESET_PC);
      if (mem_write !== 1'b0)
        report_mismatch("mem_write", {31'b0, mem_write}, 32'h0);
    end
    reset = 1'b0;  // Released on a falling edge
  endtask

  // Loads, predicts and runs the program, then checks stores and pc holds
  task automatic run_program(input int exp_holds);
    int    idx;
    int    cycles;
    int    idle;
    int    holds;
    logic  gave_up;
    word_t prev_pc;
    word_t end_pc;
    load_program();
    predict_stores();
    reset_dut();
    idx     = 0;
    cycles  = 0;
    idle    = 0;
    holds   = 0;
    gave_up = 1'b0;
    prev_pc = pc;
    end_pc  = word_t'((prog.size() + DRAIN) * 4);
    while (pc < end_pc && cycles < RUN_LIMIT && !gave_up)
    begin
      @(negedge clk);
      cycles++;
      idle++;
      if (pc == prev_pc)
        holds++;  // Load-use stall
      else if (pc != prev_pc + PC_STEP)
        report_mismatch("pc", pc, prev_pc + PC_STEP);
      prev_pc = pc;
      if (mem_write)
      begin
        idle = 0;
        if (idx >= exp_addr.size())
          report_problem($sformatf("unexpected store of %h to %h", mem_wdata, mem_addr));
        else
        begin
          if (mem_addr !== exp_addr[idx])
            report_mismatch("mem_addr", mem_addr, exp_addr[idx]);
          if (mem_wdata !== exp_data[idx])
            report_mismatch("mem_wdata", mem_wdata, exp_data[idx]);
        end
        idx++;
      end
      if (idx < exp_addr.size() && idle > STORE_TIMEOUT)
        gave_up = 1'b1;
    end
    if (cycles >= RUN_LIMIT)
      report_problem($sformatf("pc stuck near %h, program never finished", pc));
    if (idx < exp_addr.size())
      report_problem($sformatf("store %0d to address %h never appeared", idx, exp_addr[idx]));
    if (holds != exp_holds)
      report_mismatch("pc hold cycles", word_t'(holds), word_t'(exp_holds));
  endtask

  `include "tb_tests.svh"

  initial
  begin
    int n;
    seed = 90;
    for (n = 0; n < IMEM_WORDS; n++)
      imem[n] = NOP_INST;
    for (n = 0; n < DMEM_WORDS; n++)
      dmem[n] = $random(seed);  // Load data for the tests
    for (n = 0; n < REG_COUNT; n++)
      model_regs[n] = '0;
    reset_and_fetch();
    register_alu_ops();
    immediate_ops();
    forwarding_paths();
    load_use_stall();
    zero_reg_and_unknown();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
